// ==== design/rv_isa_pkg.sv ====
// rv32 opcode, funct3 and funct7 codes for the m extension, r-type instruction layout
package rv_isa_pkg;

    // major opcode shared by all register-register alu ops
    localparam logic [6:0] OPC_OP    = 7'b0110011;

    // funct7 value that selects the m extension
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // multiply group, funct3[2] low
    // low word of product
    localparam logic [2:0] F3_MUL    = 3'b000;
    // high word, signed x signed
    localparam logic [2:0] F3_MULH   = 3'b001;
    // high word, signed x unsigned
    localparam logic [2:0] F3_MULHSU = 3'b010;
    // high word, unsigned x unsigned
    localparam logic [2:0] F3_MULHU  = 3'b011;

    // divide group, funct3[2] high
    // signed quotient
    localparam logic [2:0] F3_DIV    = 3'b100;
    // unsigned quotient
    localparam logic [2:0] F3_DIVU   = 3'b101;
    // signed remainder
    localparam logic [2:0] F3_REM    = 3'b110;
    // unsigned remainder
    localparam logic [2:0] F3_REMU   = 3'b111;

    // r-type word, msb first
    // bits 31:25
    // bits 24:20
    // bits 19:15
    // bits 14:12
    // bits 11:7
    // bits 6:0
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rtype_t;

endpackage

// ==== design/exu_pkg.sv ====
// execute stage structs: divider request and result, jump request, register writeback
package exu_pkg;

    // request into the divider
    // start is a one-cycle strobe, sampled only while idle
    // op carries funct3 of the divide instruction
    // rd is kept by the divider until the result is out
    typedef struct packed {
        logic        start;
        logic [31:0] dividend;
        logic [31:0] divisor;
        logic [2:0]  op;
        logic [4:0]  rd;
    } div_req_t;

    // divider status and result
    // ready pulses one cycle with a valid result
    // busy high while iterating, low again in the ready cycle
    // rd echoes the destination captured at start
    typedef struct packed {
        logic        ready;
        logic        busy;
        logic [31:0] result;
        logic [4:0]  rd;
    } div_res_t;

    // redirect to the front end
    // flag is a level for one cycle, addr valid only with flag
    typedef struct packed {
        logic        flag;
        logic [31:0] addr;
    } jump_t;

    // one register file write port
    // we qualifies waddr and wdata
    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } wb_t;

endpackage

// ==== design/exu_div_ctrl.sv ====
// division control: decode, divider start, hold and jump, divide result writeback
`timescale 1ns/100ps

module exu_div_ctrl (
    input  rv_isa_pkg::rtype_t inst_i,
    input  logic [31:0]        rs1_data_i,
    input  logic [31:0]        rs2_data_i,
    input  logic [31:0]        jump_base_i,
    input  logic [31:0]        jump_offset_i,
    input  logic               int_assert_i,
    input  exu_pkg::div_res_t  div_res_i,
    output exu_pkg::div_req_t  div_req_o,
    output logic               hold_o,
    output exu_pkg::jump_t     jump_o,
    output exu_pkg::wb_t       wb_o
);
    import rv_isa_pkg::*;

    // instruction is one of div, divu, rem, remu
    logic        is_div;
    // division actually issued this cycle
    logic        issue;
    // redirect target
    logic [31:0] jump_target;

    assign jump_target = jump_base_i + jump_offset_i;

    // decode of the divide group
    always_comb begin
        is_div = 1'b0;
        if ((inst_i.opcode == OPC_OP) && (inst_i.funct7 == F7_MULDIV)) begin
            case (inst_i.funct3)
                F3_DIV, F3_DIVU, F3_REM, F3_REMU: begin
                    is_div = 1'b1;
                end
                default: begin
                    is_div = 1'b0;
                end
            endcase
        end
    end

    // pending interrupt wins over a new division
    // divider must be idle to take a start
    assign issue = is_div && !int_assert_i && !div_res_i.busy;

    // request towards the divider
    always_comb begin
        div_req_o.start    = issue;
        div_req_o.dividend = rs1_data_i;
        div_req_o.divisor  = rs2_data_i;
        div_req_o.op       = inst_i.funct3;
        div_req_o.rd       = inst_i.rd;
    end

    // stall for the issue cycle and the whole iteration
    // released in the ready cycle, busy is already low there
    assign hold_o = issue || div_res_i.busy;

    // front end refetches once the division is under way
    always_comb begin
        jump_o.flag = issue;
        if (issue) begin
            jump_o.addr = jump_target;
        end else begin
            jump_o.addr = '0;
        end
    end

    // result goes out independent of the current instruction
    // so a divide in the ready cycle does not drop the old result
    always_comb begin
        wb_o.we    = div_res_i.ready;
        wb_o.waddr = '0;
        wb_o.wdata = '0;
        if (div_res_i.ready) begin
            // rd comes from the divider, not from inst_i
            wb_o.waddr = div_res_i.rd;
            wb_o.wdata = div_res_i.result;
        end
    end

endmodule

// ==== design/div_core.sv ====
// iterative restoring radix-2 divider, signed and unsigned, risc-v corner cases
`timescale 1ns/100ps

module div_core (
    input  logic              clk,
    input  logic              reset_i,
    input  exu_pkg::div_req_t req_i,
    output exu_pkg::div_res_t res_o
);
    import rv_isa_pkg::*;

    // control state
    logic        busy_q;
    logic        ready_q;
    logic [4:0]  cnt_q;

    // datapath state
    // partial remainder
    logic [31:0] rem_q;
    // dividend bits shifting out, quotient bits shifting in
    logic [31:0] quo_q;
    // divisor magnitude
    logic [31:0] dsr_q;
    logic [31:0] result_q;
    logic [2:0]  op_q;
    logic [4:0]  rd_q;
    logic        neg_quo_q;
    logic        neg_rem_q;

    // start side decode
    logic        accept;
    logic        op_signed;
    logic        op_rem;
    logic        dvd_neg;
    logic        dsr_neg;
    logic [31:0] dvd_abs;
    logic [31:0] dsr_abs;
    logic        div_zero;
    logic        overflow;
    logic [31:0] special_res;

    // one iteration step
    logic [32:0] rem_shift;
    logic [32:0] diff;
    logic        take;
    logic [31:0] rem_next;
    logic [31:0] quo_next;
    logic [31:0] quo_final;
    logic [31:0] rem_final;
    logic        op_rem_q;
    logic        last;

    assign accept    = req_i.start && !busy_q;
    assign op_signed = (req_i.op == F3_DIV) || (req_i.op == F3_REM);
    assign op_rem    = (req_i.op == F3_REM) || (req_i.op == F3_REMU);
    assign dvd_neg   = op_signed && req_i.dividend[31];
    assign dsr_neg   = op_signed && req_i.divisor[31];
    assign dvd_abs   = dvd_neg ? -req_i.dividend : req_i.dividend;
    assign dsr_abs   = dsr_neg ? -req_i.divisor : req_i.divisor;

    // x / 0 and min / -1 finish on the next cycle
    assign div_zero  = (req_i.divisor == 32'h0000_0000);
    assign overflow  = op_signed && (req_i.dividend == 32'h8000_0000) &&
                       (req_i.divisor == 32'hffff_ffff);

    // div by zero: q = all ones, r = dividend
    // overflow: q = dividend, r = 0
    always_comb begin
        if (div_zero) begin
            special_res = op_rem ? req_i.dividend : 32'hffff_ffff;
        end else begin
            special_res = op_rem ? 32'h0000_0000 : req_i.dividend;
        end
    end

    // shift in next dividend bit, trial subtract
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, dsr_q};
    // no borrow means divisor fits
    assign take      = !diff[32];
    assign rem_next  = take ? diff[31:0] : rem_shift[31:0];
    assign quo_next  = {quo_q[30:0], take};

    // sign fix, remainder follows the dividend
    assign quo_final = neg_quo_q ? -quo_next : quo_next;
    assign rem_final = neg_rem_q ? -rem_next : rem_next;
    assign op_rem_q  = (op_q == F3_REM) || (op_q == F3_REMU);
    assign last      = (cnt_q == 5'd31);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= 1'b0;
            if (busy_q) begin
                cnt_q <= cnt_q + 5'd1;
                // 32nd step, busy drops as ready rises
                if (last) begin
                    busy_q  <= 1'b0;
                    ready_q <= 1'b1;
                end
            end else if (accept) begin
                cnt_q <= '0;
                if (div_zero || overflow) begin
                    ready_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            if (last) begin
                result_q <= op_rem_q ? rem_final : quo_final;
            end
        end else if (accept) begin
            rem_q     <= '0;
            quo_q     <= dvd_abs;
            dsr_q     <= dsr_abs;
            op_q      <= req_i.op;
            rd_q      <= req_i.rd;
            neg_quo_q <= dvd_neg ^ dsr_neg;
            neg_rem_q <= dvd_neg;
            // only seen when the early path fires
            result_q  <= special_res;
        end
    end

    assign res_o.ready  = ready_q;
    assign res_o.busy   = busy_q;
    assign res_o.result = result_q;
    assign res_o.rd     = rd_q;

endmodule

// ==== design/exu_mul.sv ====
// two-stage pipelined multiplier for mul, mulh, mulhsu, mulhu
`timescale 1ns/100ps

module exu_mul (
    input  logic               clk,
    input  logic               reset_i,
    input  rv_isa_pkg::rtype_t inst_i,
    input  logic [31:0]        rs1_data_i,
    input  logic [31:0]        rs2_data_i,
    input  logic               int_assert_i,
    output exu_pkg::wb_t       wb_o
);
    import rv_isa_pkg::*;

    // decode
    logic               is_mul;
    logic               a_signed;
    logic               b_signed;
    // 33-bit operands cover every signedness mix
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod;

    // stage 1
    logic               v1_q;
    logic [4:0]         rd1_q;
    logic               hi1_q;
    logic [65:0]        prod1_q;

    // stage 2
    logic               v2_q;
    logic [4:0]         rd2_q;
    logic [31:0]        data2_q;

    always_comb begin
        is_mul   = 1'b0;
        a_signed = 1'b0;
        b_signed = 1'b0;
        // interrupt blocks new multiplies too
        if ((inst_i.opcode == OPC_OP) && (inst_i.funct7 == F7_MULDIV) && !int_assert_i) begin
            case (inst_i.funct3)
                F3_MUL, F3_MULHU: begin
                    is_mul = 1'b1;
                end
                F3_MULH: begin
                    is_mul   = 1'b1;
                    a_signed = 1'b1;
                    b_signed = 1'b1;
                end
                F3_MULHSU: begin
                    is_mul   = 1'b1;
                    a_signed = 1'b1;
                end
                default: begin
                    is_mul = 1'b0;
                end
            endcase
        end
    end

    assign a_ext = {a_signed & rs1_data_i[31], rs1_data_i};
    assign b_ext = {b_signed & rs2_data_i[31], rs2_data_i};
    assign prod  = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= is_mul;
            v2_q <= v1_q;
        end
    end

    always_ff @(posedge clk) begin
        rd1_q   <= inst_i.rd;
        // every code but mul wants the upper word
        hi1_q   <= (inst_i.funct3 != F3_MUL);
        prod1_q <= prod;
        rd2_q   <= rd1_q;
        data2_q <= hi1_q ? prod1_q[63:32] : prod1_q[31:0];
    end

    assign wb_o.we    = v2_q;
    assign wb_o.waddr = rd2_q;
    assign wb_o.wdata = data2_q;

endmodule

// ==== design/exu_md_merge.sv ====
// multiply/divide writeback merge into one registered write port, pipeline hold
`timescale 1ns/100ps

module exu_md_merge (
    input  logic         clk,
    input  logic         reset_i,
    input  exu_pkg::wb_t mul_wb_i,
    input  exu_pkg::wb_t div_wb_i,
    input  logic         div_hold_i,
    output exu_pkg::wb_t wb_o,
    output logic         hold_o
);
    import exu_pkg::*;

    // winner of this cycle
    wb_t         sel_wb;
    // write port register
    logic        we_q;
    logic [4:0]  waddr_q;
    logic [31:0] wdata_q;

    // divide first, multiply otherwise
    // both at once should not happen, but divide is safer to keep
    always_comb begin
        if (div_wb_i.we) begin
            sel_wb = div_wb_i;
        end else begin
            sel_wb = mul_wb_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            we_q <= 1'b0;
        end else begin
            // x0 is hardwired zero, never written
            we_q <= sel_wb.we && (sel_wb.waddr != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        waddr_q <= sel_wb.waddr;
        wdata_q <= sel_wb.wdata;
    end

    assign wb_o.we    = we_q;
    assign wb_o.waddr = waddr_q;
    assign wb_o.wdata = wdata_q;

    // only the divider stalls, same cycle
    assign hold_o = div_hold_i;

endmodule

// ==== design/exu_muldiv_top.sv ====
// m extension execute block: division control, divider, multiplier, writeback merge
`timescale 1ns/100ps

module exu_muldiv_top (
    input  logic               clk,
    input  logic               reset_i,
    input  rv_isa_pkg::rtype_t inst_i,
    input  logic [31:0]        rs1_data_i,
    input  logic [31:0]        rs2_data_i,
    input  logic [31:0]        jump_base_i,
    input  logic [31:0]        jump_offset_i,
    input  logic               int_assert_i,
    output logic               hold_o,
    output exu_pkg::jump_t     jump_o,
    output exu_pkg::wb_t       wb_o
);
    import exu_pkg::*;

    // control to divider
    div_req_t div_req;
    // divider back to control
    div_res_t div_res;
    // writebacks into the merge
    wb_t      div_wb;
    wb_t      mul_wb;
    logic     div_hold;

    exu_div_ctrl div_ctrl0 (
        .inst_i        (inst_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .jump_base_i   (jump_base_i),
        .jump_offset_i (jump_offset_i),
        .int_assert_i  (int_assert_i),
        .div_res_i     (div_res),
        .div_req_o     (div_req),
        .hold_o        (div_hold),
        .jump_o        (jump_o),
        .wb_o          (div_wb)
    );

    div_core div0 (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (div_req),
        .res_o   (div_res)
    );

    exu_mul mul0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .int_assert_i (int_assert_i),
        .wb_o         (mul_wb)
    );

    exu_md_merge merge0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .mul_wb_i   (mul_wb),
        .div_wb_i   (div_wb),
        .div_hold_i (div_hold),
        .wb_o       (wb_o),
        .hold_o     (hold_o)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
// testbench clock and reset source
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // released on a falling edge, same as the other inputs
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// ==== bench/tb_muldiv.sv ====
// testbench for the m extension execute block: stimulus, reference model, assertions, watchdog
`timescale 1ns/100ps

module tb_muldiv;
    import rv_isa_pkg::*;
    import exu_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_MUL      = 24;
    localparam int N_DIV      = 8;
    localparam int N_SPECIAL  = 4;
    // issue, 32 steps, ready, write port, slack
    localparam int DIV_MAX    = 40;
    localparam int WATCHDOG_CYCLES = 5 + N_MUL + 30 + (N_DIV + N_SPECIAL + 1) * (DIV_MAX + 6) + 100;
    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    logic        clk;
    logic        reset_i;
    rtype_t      inst_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic [31:0] jump_base_i;
    logic [31:0] jump_offset_i;
    logic        int_assert_i;
    logic        hold_o;
    jump_t       jump_o;
    wb_t         wb_o;

    logic [31:0] lfsr;
    int          err_cnt;
    int          test_cnt;
    // posedge count mod 8, indexes the expected multiply ring
    logic [2:0]  slot;
    wb_t         exp_ring [0:7];
    // expectation for the coming posedge
    wb_t         exp_mul;
    // divide state as seen from outside
    logic        div_issue_now;
    logic [31:0] exp_jump;
    logic [4:0]  exp_div_rd;
    logic [31:0] exp_div_data;
    logic        div_pending;
    // hold dropped last cycle, writeback due now
    logic        rel_q;
    int          div_age;

    tb_clock_gen clk_gen0 (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    exu_muldiv_top dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_i        (inst_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .jump_base_i   (jump_base_i),
        .jump_offset_i (jump_offset_i),
        .int_assert_i  (int_assert_i),
        .hold_o        (hold_o),
        .jump_o        (jump_o),
        .wb_o          (wb_o)
    );

    // wrong value seen by a check
    task automatic flag_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // anything else that went wrong
    task automatic flag_problem(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // risc-v multiply rules on 64-bit products
    function automatic logic [31:0] mul_model(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic        [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (f3)
            F3_MULH:   p = sa * sb;
            F3_MULHSU: p = sa * $signed({32'h0, b});
            default:   p = {32'h0, a} * {32'h0, b};
        endcase
        return (f3 == F3_MUL) ? p[31:0] : p[63:32];
    endfunction

    // risc-v divide rules, truncating toward zero
    function automatic logic [31:0] div_model(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
        logic        sgn;
        logic [31:0] q;
        logic [31:0] r;
        sgn = (f3 == F3_DIV) || (f3 == F3_REM);
        if (b == 32'h0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return ((f3 == F3_REM) || (f3 == F3_REMU)) ? r : q;
    endfunction

    // drive one m-extension op and record its outcome
    task automatic issue_op(input logic [2:0] f3, input logic [4:0] rd, input logic [31:0] a,
                            input logic [31:0] b, input logic intr);
        rtype_t      w;
        logic [31:0] base;
        logic [31:0] offs;
        w    = '{funct7: F7_MULDIV, rs2: 5'd2, rs1: 5'd1, funct3: f3, rd: rd, opcode: OPC_OP};
        base = rand_bits(32);
        offs = rand_bits(32);
        @(negedge clk);
        inst_i        = w;
        rs1_data_i    = a;
        rs2_data_i    = b;
        jump_base_i   = base;
        jump_offset_i = offs;
        int_assert_i  = intr;
        // funct3[2] marks the divide group
        div_issue_now = f3[2] && !intr;
        if (f3[2] && !intr) begin
            exp_jump     = base + offs;
            exp_div_rd   = rd;
            exp_div_data = div_model(f3, a, b);
        end else if (!f3[2] && !intr && rd != 5'd0) begin
            // seen at the third posedge after issue
            exp_ring[slot + 3'd3] = {1'b1, rd, mul_model(f3, a, b)};
        end
    endtask

    task automatic drive_nop();
        @(negedge clk);
        inst_i        = rtype_t'(NOP_WORD);
        int_assert_i  = 1'b0;
        div_issue_now = 1'b0;
    endtask

    // nops until the divide writeback, bounded
    task automatic wait_div_done();
        int n;
        n = 0;
        drive_nop();
        while (div_pending && n < DIV_MAX + 4) begin
            drive_nop();
            n++;
        end
        if (div_pending) begin
            flag_problem($sformatf("divide gave no writeback within %0d cycles", n));
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        test_cnt++;
        $display("%s finished with %0d errors", name, err_cnt - err_before);
    endtask

    // move next expectation out of the ring
    always @(negedge clk) begin
        exp_mul        = exp_ring[slot];
        exp_ring[slot] = '0;
    end

    always @(posedge clk) begin
        slot <= slot + 3'd1;
        if (reset_i) begin
            div_pending <= 1'b0;
            rel_q       <= 1'b0;
        end else if (rel_q) begin
            div_pending <= 1'b0;
            rel_q       <= 1'b0;
        end else if (div_pending) begin
            rel_q   <= !hold_o;
            div_age <= div_age + 1;
        end else if (div_issue_now) begin
            div_pending <= 1'b1;
            div_age     <= 0;
        end
    end

    // divide issue: hold, jump and target together
    a_issue: assert property (@(posedge clk) disable iff (reset_i)
        div_issue_now |-> (hold_o && jump_o.flag && jump_o.addr == exp_jump))
        else flag_mismatch($sformatf("issue hold %0b jump %0b addr %h, expected %h",
                                     hold_o, jump_o.flag, jump_o.addr, exp_jump));
    a_no_jump: assert property (@(posedge clk) disable iff (reset_i)
        !div_issue_now |-> !jump_o.flag)
        else flag_mismatch("jump raised without a divide issue");
    a_no_hold: assert property (@(posedge clk) disable iff (reset_i)
        (!div_issue_now && !div_pending) |-> !hold_o)
        else flag_mismatch("hold high with no divide running");
    // single divide writeback right after hold falls, none for x0
    a_div_wb: assert property (@(posedge clk) disable iff (reset_i)
        rel_q |-> ((exp_div_rd == 5'd0) ? !wb_o.we :
                   (wb_o.we && wb_o.waddr == exp_div_rd && wb_o.wdata == exp_div_data)))
        else flag_mismatch($sformatf("divide wb %0b x%0d %h, expected x%0d %h", wb_o.we,
                                     wb_o.waddr, wb_o.wdata, exp_div_rd, exp_div_data));
    // outside that cycle only scheduled multiplies write
    a_mul_wb: assert property (@(posedge clk) disable iff (reset_i)
        !rel_q |-> (wb_o.we == exp_mul.we && (!exp_mul.we ||
                    (wb_o.waddr == exp_mul.waddr && wb_o.wdata == exp_mul.wdata))))
        else flag_mismatch($sformatf("wb %0b x%0d %h, expected %0b x%0d %h", wb_o.we,
                                     wb_o.waddr, wb_o.wdata, exp_mul.we, exp_mul.waddr,
                                     exp_mul.wdata));
    a_div_age: assert property (@(posedge clk) disable iff (reset_i)
        div_pending |-> (div_age < DIV_MAX))
        else flag_problem($sformatf("divide still running after %0d cycles", div_age));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        int          e0;
        int          i;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        inst_i        = rtype_t'(NOP_WORD);
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        jump_base_i   = '0;
        jump_offset_i = '0;
        int_assert_i  = 1'b0;
        div_issue_now = 1'b0;
        exp_jump      = '0;
        exp_div_rd    = '0;
        exp_div_data  = '0;
        exp_mul       = '0;
        exp_ring      = '{default: '0};
        div_pending   = 1'b0;
        rel_q         = 1'b0;
        div_age       = 0;
        slot          = '0;
        lfsr          = 32'hf9a9_82b4;
        err_cnt       = 0;
        test_cnt      = 0;
        @(negedge reset_i);

        e0 = err_cnt;
        repeat (4) drive_nop();
        finish_test("idle after reset", e0);

        // back to back, one x0 target in the stream
        e0 = err_cnt;
        for (i = 0; i < N_MUL; i++) begin
            f3 = 3'(rand_bits(2));
            a  = rand_bits(32);
            b  = rand_bits(32);
            issue_op(f3, (i == 5) ? 5'd0 : 5'(rand_bits(5)), a, b, 1'b0);
        end
        repeat (4) drive_nop();
        finish_test("multiply stream", e0);

        // shifted divisors give larger quotients
        e0 = err_cnt;
        for (i = 0; i < N_DIV; i++) begin
            f3 = 3'(rand_bits(2)) + 3'd4;
            a  = rand_bits(32);
            b  = rand_bits(32) >> rand_bits(5);
            issue_op(f3, 5'(rand_bits(5)), a, b, 1'b0);
            wait_div_done();
        end
        finish_test("random divide", e0);

        e0 = err_cnt;
        issue_op(F3_DIV, 5'd10, rand_bits(32), 32'h0, 1'b0);
        wait_div_done();
        issue_op(F3_REMU, 5'd11, rand_bits(32), 32'h0, 1'b0);
        wait_div_done();
        issue_op(F3_DIV, 5'd12, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        wait_div_done();
        issue_op(F3_REM, 5'd13, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        wait_div_done();
        finish_test("divide corner cases", e0);

        // nothing may start under an interrupt
        e0 = err_cnt;
        issue_op(F3_MULH, 5'd7, rand_bits(32), rand_bits(32), 1'b1);
        issue_op(F3_DIV, 5'd8, rand_bits(32), 32'd3, 1'b1);
        repeat (6) drive_nop();
        finish_test("interrupt blocks issue", e0);

        // nonzero divisor keeps the full latency
        e0 = err_cnt;
        issue_op(F3_MUL, 5'd14, rand_bits(32), rand_bits(32), 1'b0);
        issue_op(F3_DIVU, 5'd15, rand_bits(32), rand_bits(32) | 32'd1, 1'b0);
        wait_div_done();
        repeat (2) drive_nop();
        finish_test("multiply then divide", e0);

        repeat (4) drive_nop();
        $display("%0d tests run, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
design/rv_isa_pkg.sv
design/exu_pkg.sv
design/exu_div_ctrl.sv
design/div_core.sv
design/exu_mul.sv
design/exu_md_merge.sv
design/exu_muldiv_top.sv
bench/tb_clock_gen.sv
bench/tb_muldiv.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_muldiv -f project.f -o sim_muldiv \
    && ./obj_dir/sim_muldiv | tee /dev/stderr | grep -qx "test passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
